// File: common/ll_pkg.sv
/*
  Shared widths and PHY lane layout for the four-channel logic link slave.
  Modules refer to these constants by scoped name.
*/

package ll_pkg;

  ////////////////////
  // User channels
  ////////////////////

  // Number of user channels per direction
  localparam int NUM_CH        = 4;
  // Bits per user channel word
  localparam int CH_WIDTH      = 74;
  // All channels packed back to back
  localparam int PAYLOAD_WIDTH = NUM_CH * CH_WIDTH;

  ////////////////////
  // PHY lanes
  ////////////////////

  // Lane k occupies PHY bits k*80 upward
  //   73..0  channel data
  //   77..74 spare, always zero
  //   78     strobe
  //   79     marker
  localparam int LANE_WIDTH   = 80;
  localparam int PHY_WIDTH    = NUM_CH * LANE_WIDTH;

  // One marker userbit per lane
  localparam int MARKER_WIDTH = NUM_CH;

  // Overhead bit positions inside a lane
  localparam int MRK_BIT      = 79;
  localparam int STB_BIT      = 78;

  ////////////////////
  // Debug status word
  ////////////////////

  // Delayed online flags, all other bits zero
  localparam int STATUS_TX_ONLINE_BIT = 19;
  localparam int STATUS_RX_ONLINE_BIT = 18;

endpackage

// File: common/ll_sync_if.sv
/*
  Link bring-up state shared between the auto-sync block and the framer.
  The auto-sync side drives it, the framer only reads it.
*/

`timescale 1ns/1ps

interface ll_sync_if;

  // Transmit side online, after delay_z
  logic                            tx_online_delay;
  // Receive side online, after delay_x
  logic                            rx_online_delay;

  // Per-lane markers, already gated by online state
  logic [ll_pkg::MARKER_WIDTH-1:0] auto_mrk_userbit;
  // Strobe, high once the start delay is over
  logic                            auto_stb_userbit;

  ////////////////////
  // Views
  ////////////////////

  // Auto-sync side
  modport sync_src (
    output tx_online_delay,
    output rx_online_delay,
    output auto_mrk_userbit,
    output auto_stb_userbit
  );

  // Framer side
  modport sync_dst (
    input  tx_online_delay,
    input  rx_online_delay,
    input  auto_mrk_userbit,
    input  auto_stb_userbit
  );

endinterface

// File: auto_sync/ll_auto_sync.sv
/*
  Link bring-up sequencing. Delays rx_online by delay_x, then tx_online by
  delay_z once the receive side is up, and starts the strobe delay_y cycles
  later. Drives the gated userbits and the debug status word.
*/

`timescale 1ns/1ps

module ll_auto_sync #(
  parameter int DELAY_WIDTH = 16
) (
  input  logic                            clk_wr,
  input  logic                            rst_n,

  // Raw online requests
  input  logic                            tx_online,
  input  logic                            rx_online,

  // User overhead bits
  input  logic [ll_pkg::MARKER_WIDTH-1:0] tx_mrk_userbit,
  input  logic                            tx_stb_userbit,

  // Delay settings, in clk_wr cycles
  input  logic [DELAY_WIDTH-1:0]          delay_x_value,
  input  logic [DELAY_WIDTH-1:0]          delay_y_value,
  input  logic [DELAY_WIDTH-1:0]          delay_z_value,

  ll_sync_if.sync_src                     sync,

  output logic [31:0]                     debug_status
);

  // Counter step shared by all three delays
  // Cleared while idle, counts up and holds at the limit
  function automatic logic [DELAY_WIDTH-1:0] cnt_step(
    input logic                   run,
    input logic [DELAY_WIDTH-1:0] cnt,
    input logic [DELAY_WIDTH-1:0] limit
  );
    if (!run) begin
      return '0;
    end else if (cnt < limit) begin
      return cnt + 1'b1;
    end else begin
      return cnt;
    end
  endfunction

  ////////////////////
  // State
  ////////////////////

  logic [DELAY_WIDTH-1:0] rx_cnt_q;
  logic [DELAY_WIDTH-1:0] rx_cnt_d;
  logic [DELAY_WIDTH-1:0] tx_cnt_q;
  logic [DELAY_WIDTH-1:0] tx_cnt_d;
  logic [DELAY_WIDTH-1:0] stb_cnt_q;
  logic [DELAY_WIDTH-1:0] stb_cnt_d;

  logic                   rx_flag_q;
  logic                   rx_flag_d;
  logic                   tx_flag_q;
  logic                   tx_flag_d;
  logic                   tx_run;

  logic [31:0]            status_q;
  logic [31:0]            status_d;

  // Transmit side waits for the delayed receive side
  assign tx_run = tx_online && rx_flag_q;

  always_comb begin
    rx_cnt_d  = cnt_step(rx_online, rx_cnt_q, delay_x_value);
    tx_cnt_d  = cnt_step(tx_run, tx_cnt_q, delay_z_value);
    // Strobe delay runs from the cycle tx_online_delay is seen high
    stb_cnt_d = cnt_step(tx_flag_q, stb_cnt_q, delay_y_value);

    // Flag set on the edge the count reaches the delay, drops with its input
    rx_flag_d = rx_online && (rx_cnt_q >= delay_x_value);
    tx_flag_d = tx_run && (tx_cnt_q >= delay_z_value);

    // Status word tracks the flags in the same cycle
    status_d = '0;
    status_d[ll_pkg::STATUS_TX_ONLINE_BIT] = tx_flag_d;
    status_d[ll_pkg::STATUS_RX_ONLINE_BIT] = rx_flag_d;
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_cnt_q  <= '0;
      tx_cnt_q  <= '0;
      stb_cnt_q <= '0;
      rx_flag_q <= 1'b0;
      tx_flag_q <= 1'b0;
      status_q  <= '0;
    end else begin
      rx_cnt_q  <= rx_cnt_d;
      tx_cnt_q  <= tx_cnt_d;
      stb_cnt_q <= stb_cnt_d;
      rx_flag_q <= rx_flag_d;
      tx_flag_q <= tx_flag_d;
      status_q  <= status_d;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign sync.rx_online_delay  = rx_flag_q;
  assign sync.tx_online_delay  = tx_flag_q;

  // Markers follow the user bits for as long as the link is up
  assign sync.auto_mrk_userbit = tx_flag_q ? tx_mrk_userbit : '0;

  // Strobe stays on after the start delay, user bit acts as enable
  assign sync.auto_stb_userbit = tx_flag_q && (stb_cnt_q >= delay_y_value) &&
                                 tx_stb_userbit;

  assign debug_status = status_q;

endmodule

// File: source/ll_chan_map.sv
/*
  Channel mapping between the four user channels and the 296-bit payload.
  Gen2 keeps channel order, gen1 reverses it in both directions.
  Purely combinational, the framer holds the pipeline registers.
*/

`timescale 1ns/1ps

module ll_chan_map (
  // Channels from the user, toward the PHY
  input  logic [ll_pkg::CH_WIDTH-1:0]      ch0_rx_data,
  input  logic [ll_pkg::CH_WIDTH-1:0]      ch1_rx_data,
  input  logic [ll_pkg::CH_WIDTH-1:0]      ch2_rx_data,
  input  logic [ll_pkg::CH_WIDTH-1:0]      ch3_rx_data,

  // Channels toward the user, from the PHY
  output logic [ll_pkg::CH_WIDTH-1:0]      ch0_tx_data,
  output logic [ll_pkg::CH_WIDTH-1:0]      ch1_tx_data,
  output logic [ll_pkg::CH_WIDTH-1:0]      ch2_tx_data,
  output logic [ll_pkg::CH_WIDTH-1:0]      ch3_tx_data,

  // Payload words on the framer side
  output logic [ll_pkg::PAYLOAD_WIDTH-1:0] tx_payload,
  input  logic [ll_pkg::PAYLOAD_WIDTH-1:0] rx_payload,

  input  logic                             m_gen2_mode
);

  // Channels as arrays so the mapping is one loop
  logic [ll_pkg::CH_WIDTH-1:0] ch_in  [ll_pkg::NUM_CH];
  logic [ll_pkg::CH_WIDTH-1:0] ch_out [ll_pkg::NUM_CH];

  assign ch_in[0] = ch0_rx_data;
  assign ch_in[1] = ch1_rx_data;
  assign ch_in[2] = ch2_rx_data;
  assign ch_in[3] = ch3_rx_data;

  ////////////////////
  // Slice mapping
  ////////////////////

  always_comb begin
    for (int k = 0; k < ll_pkg::NUM_CH; k++) begin
      if (m_gen2_mode) begin
        // Straight order
        tx_payload[k*ll_pkg::CH_WIDTH +: ll_pkg::CH_WIDTH] = ch_in[k];
        ch_out[k] = rx_payload[k*ll_pkg::CH_WIDTH +: ll_pkg::CH_WIDTH];
      end else begin
        // Gen1 master sees channel k in slice 3-k
        tx_payload[k*ll_pkg::CH_WIDTH +: ll_pkg::CH_WIDTH] =
          ch_in[ll_pkg::NUM_CH-1-k];
        ch_out[ll_pkg::NUM_CH-1-k] =
          rx_payload[k*ll_pkg::CH_WIDTH +: ll_pkg::CH_WIDTH];
      end
    end
  end

  assign ch0_tx_data = ch_out[0];
  assign ch1_tx_data = ch_out[1];
  assign ch2_tx_data = ch_out[2];
  assign ch3_tx_data = ch_out[3];

endmodule

// File: source/ll_phy_framer.sv
/*
  PHY word framing. Transmit side registers the payload into four 80-bit
  lanes and adds marker and strobe. Receive side registers the lane data
  bits back into the payload and drops the overhead bits.
*/

`timescale 1ns/1ps

module ll_phy_framer (
  input  logic                             clk_wr,
  input  logic                             rst_n,

  // Payload side
  input  logic [ll_pkg::PAYLOAD_WIDTH-1:0] tx_payload,
  output logic [ll_pkg::PAYLOAD_WIDTH-1:0] rx_payload,

  // PHY side
  output logic [ll_pkg::PHY_WIDTH-1:0]     tx_phy0,
  input  logic [ll_pkg::PHY_WIDTH-1:0]     rx_phy0,

  input  logic                             m_gen2_mode,

  ll_sync_if.sync_dst                      sync
);

  logic [ll_pkg::PHY_WIDTH-1:0]     tx_frame;
  logic [ll_pkg::PHY_WIDTH-1:0]     tx_phy_q;
  logic [ll_pkg::PAYLOAD_WIDTH-1:0] rx_strip;
  logic [ll_pkg::PAYLOAD_WIDTH-1:0] rx_payload_q;
  logic [ll_pkg::MARKER_WIDTH-1:0]  mrk_mask;

  // Gen1 carries markers in lanes 0 and 2 only
  assign mrk_mask = m_gen2_mode ? '1 : ll_pkg::MARKER_WIDTH'('b0101);

  ////////////////////
  // Transmit framing
  ////////////////////

  always_comb begin
    // Spare bits stay zero
    tx_frame = '0;
    for (int k = 0; k < ll_pkg::NUM_CH; k++) begin
      tx_frame[k*ll_pkg::LANE_WIDTH +: ll_pkg::CH_WIDTH] =
        tx_payload[k*ll_pkg::CH_WIDTH +: ll_pkg::CH_WIDTH];
      // Same strobe in every lane
      tx_frame[k*ll_pkg::LANE_WIDTH + ll_pkg::STB_BIT] = sync.auto_stb_userbit;
      tx_frame[k*ll_pkg::LANE_WIDTH + ll_pkg::MRK_BIT] =
        sync.auto_mrk_userbit[k] & mrk_mask[k];
    end
  end

  // One cycle of latency, all zero while offline
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy_q <= '0;
    end else if (sync.tx_online_delay) begin
      tx_phy_q <= tx_frame;
    end else begin
      tx_phy_q <= '0;
    end
  end

  assign tx_phy0 = tx_phy_q;

  ////////////////////
  // Receive strip
  ////////////////////

  // Keep bits 73..0 of each lane, marker strobe and spares are dropped
  always_comb begin
    for (int k = 0; k < ll_pkg::NUM_CH; k++) begin
      rx_strip[k*ll_pkg::CH_WIDTH +: ll_pkg::CH_WIDTH] =
        rx_phy0[k*ll_pkg::LANE_WIDTH +: ll_pkg::CH_WIDTH];
    end
  end

  // Holds zero until the receive side is up
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_payload_q <= '0;
    end else if (sync.rx_online_delay) begin
      rx_payload_q <= rx_strip;
    end else begin
      rx_payload_q <= '0;
    end
  end

  assign rx_payload = rx_payload_q;

endmodule

// File: source/axi_fourchan_tier2_slave_top.sv
/*
  Four-channel logic link slave, tier 2, single clock domain.
  Connects auto-sync, channel mapping and PHY framing. FIFOs and credit
  logic are bypassed, so data moves every clock.
*/

`timescale 1ns/1ps

module axi_fourchan_tier2_slave_top #(
  parameter int DELAY_WIDTH = 16
) (
  input  logic                             clk_wr,
  input  logic                             rst_n,

  // Control
  input  logic                             tx_online,
  input  logic                             rx_online,
  // Credits have no use with the FIFOs bypassed
  input  logic [7:0]                       init_rx_credit,

  // PHY
  output logic [ll_pkg::PHY_WIDTH-1:0]     tx_phy0,
  input  logic [ll_pkg::PHY_WIDTH-1:0]     rx_phy0,

  // Channels toward the user
  output logic [ll_pkg::CH_WIDTH-1:0]      ch0_tx_data,
  output logic [ll_pkg::CH_WIDTH-1:0]      ch1_tx_data,
  output logic [ll_pkg::CH_WIDTH-1:0]      ch2_tx_data,
  output logic [ll_pkg::CH_WIDTH-1:0]      ch3_tx_data,

  // Channels from the user
  input  logic [ll_pkg::CH_WIDTH-1:0]      ch0_rx_data,
  input  logic [ll_pkg::CH_WIDTH-1:0]      ch1_rx_data,
  input  logic [ll_pkg::CH_WIDTH-1:0]      ch2_rx_data,
  input  logic [ll_pkg::CH_WIDTH-1:0]      ch3_rx_data,

  // Debug
  output logic [31:0]                      rx_tx_debug_status,
  output logic [31:0]                      tx_rx_debug_status,

  // Configuration
  input  logic                             m_gen2_mode,
  input  logic [ll_pkg::MARKER_WIDTH-1:0]  tx_mrk_userbit,
  input  logic                             tx_stb_userbit,
  input  logic [DELAY_WIDTH-1:0]           delay_x_value,
  input  logic [DELAY_WIDTH-1:0]           delay_y_value,
  input  logic [DELAY_WIDTH-1:0]           delay_z_value
);

  ////////////////////
  // Wires
  ////////////////////

  logic [ll_pkg::PAYLOAD_WIDTH-1:0] tx_payload;
  logic [ll_pkg::PAYLOAD_WIDTH-1:0] rx_payload;
  logic [31:0]                      debug_status;

  ll_sync_if sync_bus ();

  // Bring-up sequencing
  ll_auto_sync #(
    .DELAY_WIDTH (DELAY_WIDTH)
  ) ll_auto_sync_inst (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .sync           (sync_bus.sync_src),
    .debug_status   (debug_status)
  );

  // User channel ordering
  ll_chan_map ll_chan_map_inst (
    .ch0_rx_data (ch0_rx_data),
    .ch1_rx_data (ch1_rx_data),
    .ch2_rx_data (ch2_rx_data),
    .ch3_rx_data (ch3_rx_data),
    .ch0_tx_data (ch0_tx_data),
    .ch1_tx_data (ch1_tx_data),
    .ch2_tx_data (ch2_tx_data),
    .ch3_tx_data (ch3_tx_data),
    .tx_payload  (tx_payload),
    .rx_payload  (rx_payload),
    .m_gen2_mode (m_gen2_mode)
  );

  // Lane framing toward the PHY
  ll_phy_framer ll_phy_framer_inst (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_payload  (tx_payload),
    .rx_payload  (rx_payload),
    .tx_phy0     (tx_phy0),
    .rx_phy0     (rx_phy0),
    .m_gen2_mode (m_gen2_mode),
    .sync        (sync_bus.sync_dst)
  );

  // Same status word on both debug ports
  assign rx_tx_debug_status = debug_status;
  assign tx_rx_debug_status = debug_status;

endmodule

// File: sim/tb_tests.svh
/*
  Directed tests for the link slave, included inside tb_top.
  Each task drives the DUT on the falling edge and checks one cycle later.
*/

`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

  task automatic report_error(input string msg);
    error_count++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // Counts cycles until a debug status bit reaches a value
  // Gives up after max_cycles
  task automatic wait_for_status(input int bit_pos, input logic value,
                                 input int max_cycles, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_wr);
      cycles++;
    end while (tx_rx_debug_status[bit_pos] !== value && cycles < max_cycles);
    if (tx_rx_debug_status[bit_pos] !== value) begin
      error_count++;
      $display("Timed out after %0d cycles waiting for debug status bit %0d to be %0b",
               cycles, bit_pos, value);
    end
  endtask

  task automatic bring_link_up();
    int cycles;
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_for_status(RX_BIT, 1'b1, DX + 10, cycles);
    wait_for_status(TX_BIT, 1'b1, DZ + 10, cycles);
  endtask

  // Checks lane data, spare bits and marker
  // Strobe is checked by the caller
  task automatic check_tx_lanes(input logic [PAYLOAD-1:0] sent, input logic [3:0] mrk,
                                input logic gen2);
    logic [LW-1:0]  lane;
    logic [CHW-1:0] exp_data;
    logic           exp_mrk;
    for (int k = 0; k < 4; k++) begin
      lane     = tx_phy0[k*LW +: LW];
      exp_data = gen2 ? sent[k*CHW +: CHW] : sent[(3-k)*CHW +: CHW];
      // Gen1 markers only in the even lanes
      exp_mrk  = (gen2 || k % 2 == 0) ? mrk[k] : 1'b0;
      check_count++;
      if (lane[73:0] !== exp_data || lane[77:74] !== 4'b0000 || lane[79] !== exp_mrk) begin
        report_error($sformatf("tx lane %0d is %h, expected data %h marker %b",
                               k, lane, exp_data, exp_mrk));
      end
    end
  endtask

  function automatic logic [3:0] strobe_bits(input logic [ll_pkg::PHY_WIDTH-1:0] phy);
    logic [3:0] stb;
    for (int k = 0; k < 4; k++) begin
      stb[k] = phy[k*LW + 78];
    end
    return stb;
  endfunction

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_and_bringup();
    int cycles;
    check_count++;
    if (tx_phy0 !== '0 || ch_seen !== '0 || rx_tx_debug_status !== 32'd0 ||
        tx_rx_debug_status !== 32'd0) begin
      report_error("outputs not zero after reset");
    end
    delay_x_value = DELAY_WIDTH'(DX);
    delay_y_value = DELAY_WIDTH'(DY);
    delay_z_value = DELAY_WIDTH'(DZ);
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_for_status(RX_BIT, 1'b1, DX + 10, cycles);
    check_count++;
    if (cycles < DX - 1 || cycles > DX + 1) begin
      report_error($sformatf("rx online after %0d cycles, expected %0d +-1", cycles, DX));
    end
    wait_for_status(TX_BIT, 1'b1, DZ + 10, cycles);
    check_count++;
    if (cycles < DZ - 1 || cycles > DZ + 1) begin
      report_error($sformatf("tx online after %0d cycles, expected %0d +-1", cycles, DZ));
    end
    // Only bits 19 and 18 set
    // Same word on both ports
    check_count++;
    if (tx_rx_debug_status !== 32'h000C_0000 || rx_tx_debug_status !== 32'h000C_0000) begin
      report_error($sformatf("debug words %h %h, expected 000c0000",
                             tx_rx_debug_status, rx_tx_debug_status));
    end
    tx_online = 1'b0;
    wait_for_status(TX_BIT, 1'b0, 4, cycles);
    check_count++;
    if (cycles > 1) begin
      report_error($sformatf("tx online fell after %0d cycles", cycles));
    end
    rx_online = 1'b0;
    wait_for_status(RX_BIT, 1'b0, 4, cycles);
    check_count++;
    if (cycles > 1) begin
      report_error($sformatf("rx online fell after %0d cycles", cycles));
    end
  endtask

  task automatic gen2_tx_framing();
    logic [PAYLOAD-1:0] sent;
    logic [3:0]         mrk;
    logic [3:0]         stb;
    logic [3:0]         exp_stb;
    m_gen2_mode    = 1'b1;
    tx_stb_userbit = 1'b1;
    bring_link_up();
    // Loop index plus one is the edge count since tx came online
    for (int n = 0; n < BEATS + DY; n++) begin
      sent = PAYLOAD'(rand_bits(PAYLOAD));
      mrk  = 4'(rand_bits(4));
      ch_drive       = sent;
      tx_mrk_userbit = mrk;
      @(negedge clk_wr);
      check_tx_lanes(sent, mrk, 1'b1);
      stb = strobe_bits(tx_phy0);
      // Strobe starts DY edges after online and takes one more edge to reach the PHY
      exp_stb = (n + 1 > DY) ? 4'b1111 : 4'b0000;
      check_count++;
      if (stb !== exp_stb) begin
        report_error($sformatf("strobe %b, expected %b %0d cycles after online",
                               stb, exp_stb, n + 1));
      end
    end
  endtask

  task automatic gen1_lane_mapping();
    logic [PAYLOAD-1:0] sent;
    logic [3:0]         mrk;
    m_gen2_mode = 1'b0;
    for (int n = 0; n < BEATS; n++) begin
      sent = PAYLOAD'(rand_bits(PAYLOAD));
      mrk  = 4'(rand_bits(4));
      ch_drive       = sent;
      tx_mrk_userbit = mrk;
      @(negedge clk_wr);
      check_tx_lanes(sent, mrk, 1'b0);
      check_count++;
      if (strobe_bits(tx_phy0) !== 4'b1111) begin
        report_error("gen1 strobe not set in every lane");
      end
    end
  endtask

  task automatic rx_path_mapping();
    logic [ll_pkg::PHY_WIDTH-1:0] phy;
    logic [CHW-1:0]               exp_data;
    int                           cycles;
    for (int mode = 1; mode >= 0; mode--) begin
      m_gen2_mode = mode[0];
      for (int n = 0; n < BEATS; n++) begin
        phy = rand_bits(ll_pkg::PHY_WIDTH);
        rx_phy0 = phy;
        @(negedge clk_wr);
        for (int k = 0; k < 4; k++) begin
          exp_data = mode[0] ? phy[k*LW +: CHW] : phy[(3-k)*LW +: CHW];
          check_count++;
          if (ch_seen[k*CHW +: CHW] !== exp_data) begin
            report_error($sformatf("gen%0d channel %0d is %h, expected %h",
                                   mode + 1, k, ch_seen[k*CHW +: CHW], exp_data));
          end
        end
      end
    end
    // Receive side offline
    // One more cycle drains the register
    rx_online = 1'b0;
    wait_for_status(RX_BIT, 1'b0, 4, cycles);
    @(negedge clk_wr);
    for (int n = 0; n < BEATS; n++) begin
      rx_phy0 = rand_bits(ll_pkg::PHY_WIDTH);
      @(negedge clk_wr);
      check_count++;
      if (ch_seen !== '0) begin
        report_error("channel outputs not zero while rx offline");
      end
    end
    bring_link_up();
  endtask

  task automatic strobe_enable_and_offline();
    int cycles;
    m_gen2_mode    = 1'b1;
    tx_stb_userbit = 1'b0;
    for (int n = 0; n < BEATS; n++) begin
      ch_drive = PAYLOAD'(rand_bits(PAYLOAD));
      @(negedge clk_wr);
      check_count++;
      if (strobe_bits(tx_phy0) !== 4'b0000) begin
        report_error("strobe set with tx_stb_userbit low");
      end
    end
    // Strobe start delay is long over so it returns at once
    tx_stb_userbit = 1'b1;
    @(negedge clk_wr);
    check_count++;
    if (strobe_bits(tx_phy0) !== 4'b1111) begin
      report_error("strobe not back after tx_stb_userbit rose");
    end
    tx_online = 1'b0;
    wait_for_status(TX_BIT, 1'b0, 4, cycles);
    for (int n = 0; n < 4; n++) begin
      ch_drive = PAYLOAD'(rand_bits(PAYLOAD));
      @(negedge clk_wr);
      check_count++;
      if (tx_phy0 !== '0) begin
        report_error($sformatf("tx_phy0 not zero %0d cycles after tx offline", n + 1));
      end
    end
  endtask

`endif

// File: sim/tb_top.sv
/*
  Testbench for the four-channel logic link slave. Makes clock and reset,
  drives the DUT on the falling edge and runs the directed tests from the
  included task file. Ends with one count line and the verdict.
*/

`timescale 1ns/1ps

module tb_top;

  localparam int DELAY_WIDTH  = 16;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;

  // Short names for the lane layout
  localparam int CHW     = ll_pkg::CH_WIDTH;
  localparam int LW      = ll_pkg::LANE_WIDTH;
  localparam int PAYLOAD = ll_pkg::PAYLOAD_WIDTH;
  localparam int RX_BIT  = ll_pkg::STATUS_RX_ONLINE_BIT;
  localparam int TX_BIT  = ll_pkg::STATUS_TX_ONLINE_BIT;

  // Programmed delays and beats per test
  localparam int DX        = 3;
  localparam int DY        = 4;
  localparam int DZ        = 5;
  localparam int BEATS     = 16;
  localparam int NUM_TESTS = 5;
  localparam int MARGIN    = 100;
  // At most two bring-ups and four bursts of beats per test
  localparam int LIMIT_CYCLES = RESET_CYCLES + MARGIN +
                                NUM_TESTS * (2 * (DX + DY + DZ + 4) + 4 * BEATS);

  logic                           clk_wr;
  logic                           rst_n;
  logic                           tx_online;
  logic                           rx_online;
  logic [7:0]                     init_rx_credit;
  logic [ll_pkg::PHY_WIDTH-1:0]   tx_phy0;
  logic [ll_pkg::PHY_WIDTH-1:0]   rx_phy0;
  logic [CHW-1:0]                 ch0_tx_data;
  logic [CHW-1:0]                 ch1_tx_data;
  logic [CHW-1:0]                 ch2_tx_data;
  logic [CHW-1:0]                 ch3_tx_data;
  logic [31:0]                    rx_tx_debug_status;
  logic [31:0]                    tx_rx_debug_status;
  logic                           m_gen2_mode;
  logic [ll_pkg::MARKER_WIDTH-1:0] tx_mrk_userbit;
  logic                           tx_stb_userbit;
  logic [DELAY_WIDTH-1:0]         delay_x_value;
  logic [DELAY_WIDTH-1:0]         delay_y_value;
  logic [DELAY_WIDTH-1:0]         delay_z_value;

  // Channel k sits at bits k*74 in both vectors
  logic [PAYLOAD-1:0]             ch_drive;
  logic [PAYLOAD-1:0]             ch_seen;

  int                             error_count;
  int                             check_count;
  logic [31:0]                    lfsr_state;

  assign ch_seen = {ch3_tx_data, ch2_tx_data, ch1_tx_data, ch0_tx_data};

  axi_fourchan_tier2_slave_top #(
    .DELAY_WIDTH (DELAY_WIDTH)
  ) axi_fourchan_tier2_slave_top_inst (
    .clk_wr             (clk_wr),
    .rst_n              (rst_n),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .init_rx_credit     (init_rx_credit),
    .tx_phy0            (tx_phy0),
    .rx_phy0            (rx_phy0),
    .ch0_tx_data        (ch0_tx_data),
    .ch1_tx_data        (ch1_tx_data),
    .ch2_tx_data        (ch2_tx_data),
    .ch3_tx_data        (ch3_tx_data),
    .ch0_rx_data        (ch_drive[0*CHW +: CHW]),
    .ch1_rx_data        (ch_drive[1*CHW +: CHW]),
    .ch2_rx_data        (ch_drive[2*CHW +: CHW]),
    .ch3_rx_data        (ch_drive[3*CHW +: CHW]),
    .rx_tx_debug_status (rx_tx_debug_status),
    .tx_rx_debug_status (tx_rx_debug_status),
    .m_gen2_mode        (m_gen2_mode),
    .tx_mrk_userbit     (tx_mrk_userbit),
    .tx_stb_userbit     (tx_stb_userbit),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value),
    .delay_z_value      (delay_z_value)
  );

  // Galois LFSR with taps 32 22 2 1
  // One step per bit taken
  function automatic logic [ll_pkg::PHY_WIDTH-1:0] rand_bits(input int n);
    logic [ll_pkg::PHY_WIDTH-1:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value[i] = lfsr_state[0];
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return value;
  endfunction

  `include "tb_tests.svh"

  ////////////////////
  // Clock and watchdog
  ////////////////////

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", LIMIT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    error_count    = 0;
    check_count    = 0;
    lfsr_state     = 32'heb9b_1c5f;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    init_rx_credit = 8'd0;
    rx_phy0        = '0;
    ch_drive       = '0;
    m_gen2_mode    = 1'b1;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    delay_x_value  = '0;
    delay_y_value  = '0;
    delay_z_value  = '0;

    repeat (RESET_CYCLES) @(negedge clk_wr);
    rst_n = 1'b1;

    reset_and_bringup();
    gen2_tx_framing();
    gen1_lane_mapping();
    rx_path_mapping();
    strobe_enable_and_offline();

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+sim
common/ll_pkg.sv
common/ll_sync_if.sv
auto_sync/ll_auto_sync.sv
source/ll_chan_map.sv
source/ll_phy_framer.sv
source/axi_fourchan_tier2_slave_top.sv
sim/tb_top.sv

// File: Bender.yml
package:
  name: ll_fourchan_slave

sources:
  # Package and interface first, then the blocks, then the top level
  - common/ll_pkg.sv
  - common/ll_sync_if.sv
  - auto_sync/ll_auto_sync.sv
  - source/ll_chan_map.sv
  - source/ll_phy_framer.sv
  - source/axi_fourchan_tier2_slave_top.sv

  # Testbench, top module tb_top
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_top.sv
